// ==== sim.f ====
+incdir+rtl
rtl/cpuRegPkg.sv
rtl/videoAddrPkg.sv
rtl/scrollRegs.sv
rtl/tileAddrGen.sv
rtl/tileRam.sv
rtl/tilemapGen.sv
sim/tbTilemapGen.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tbTilemapGen
FILELIST ?= sim.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim/tbTilemapGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tilemap_defs.svh"

module tbTilemapGen;

	import cpuRegPkg::*;
	import videoAddrPkg::*;

	localparam int N_TESTS = 5;

	logic                   CLK_6M;
	logic                   rst;
	logic                   hSyncN;
	logic                   vSyncN;
	logic [`CPU_ADDR_W-1:0] cpuAddr;
	logic [`DATA_W-1:0]     cpuWrData;
	logic                   cpuWe;
	logic                   regCs;
	logic                   ramCs;
	logic [`DATA_W-1:0]     cpuRdData;
	logic                   fetchStrobe;
	gfxFetch                gfxOut;
	logic [1:0]             pixLatch;
	logic [1:0][2:0]        pri;

	tilemapGen i_tilemapGen (.*);

	// 20 ns period
	always #10 CLK_6M = ~CLK_6M;

	////////////////////////////////////////////////////////////////////////////
	// reference model state
	////////////////////////////////////////////////////////////////////////////

	logic [7:0]  shadow [2**`RAM_ADDR_W];
	scrollSet    modelSet;
	logic [8:0]  mh;
	logic [7:0]  mv;
	logic        hLast;
	logic        vLast;
	logic [7:0]  idxM [2];
	// expected strobe per cycle, slot = cycle mod 4
	logic [1:0]  slot;
	logic [3:0]  expValid;
	gfxFetch     expFetch [4];
	logic [1:0]  expPix;
	logic        checkOn;
	logic        haveLast;
	logic        lastLayer;
	int          fetchSeen;
	int          testErr;
	int          testCount;
	int          failCount;
	int          errTotal;
	string       curName;
	logic [31:0] lcgState;

	// test table
	string    tblName [8];
	scrollSet tblSet [8];
	int       tblLines [8];
	int       tblFetches [8];

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic setEntry(input logic [2:0] e, input string name,
			input logic [8:0] hs0, input logic [7:0] vs0, input logic [2:0] p0,
			input logic [8:0] hs1, input logic [7:0] vs1, input logic [2:0] p1,
			input int lines, input int fetches);
		tblName[e]    = name;
		tblSet[e][0]  = {hs0, vs0, p0};
		tblSet[e][1]  = {hs1, vs1, p1};
		tblLines[e]   = lines;
		tblFetches[e] = fetches;
	endtask

	// one model step per cycle, at the falling edge where everything is stable
	task automatic modelStep();
		logic        lay;
		logic        bs;
		logic [8:0]  hp;
		logic [7:0]  vp;
		logic [12:0] a;
		logic [1:0]  ps;
		logic        hf;
		logic        vf;
		gfxFetch     f;
		if (rst) begin
			mh       = '0;
			mv       = '0;
			hLast    = 1'b1;
			vLast    = 1'b1;
			slot     = '0;
			expValid = '0;
			expPix   = '0;
			return;
		end
		if (checkOn) begin
			assert (fetchStrobe === expValid[slot]) else begin
				$display("[ERROR] %s: fetchStrobe expected %b, got %b",
					curName, expValid[slot], fetchStrobe);
				testErr++;
			end
			if (fetchStrobe && expValid[slot]) begin
				assert (gfxOut === expFetch[slot]) else begin
					$display("[ERROR] %s: gfxOut expected %h, got %h",
						curName, expFetch[slot], gfxOut);
					testErr++;
				end
				// layers take turns within a line
				assert (!haveLast || gfxOut.layer != lastLayer) else begin
					$display("[ERROR] %s: fetch layer expected %b, got %b",
						curName, !lastLayer, gfxOut.layer);
					testErr++;
				end
				haveLast  = 1'b1;
				lastLayer = gfxOut.layer;
				fetchSeen++;
			end
			assert (pixLatch === expPix) else begin
				$display("[ERROR] %s: pixLatch expected %b, got %b", curName, expPix, pixLatch);
				testErr++;
			end
		end
		// request of this cycle
		lay = mh[0];
		bs  = mh[1];
		hp  = mh + modelSet[lay].hScroll;
		vp  = mv + modelSet[lay].vScroll;
		a   = {lay, vp[7:3], hp[8:3], bs};
		if (!bs) begin
			idxM[lay] = shadow[a];
		end
		// byte 1 shows up as a fetch three cycles on
		f.layer                = lay;
		f.addr                 = {shadow[a][1:0], idxM[lay], vp[2:0], hp[2]};
		expFetch[slot + 2'd3]  = f;
		expValid[slot + 2'd3]  = bs;
		// latch strobes for the next cycle
		ps        = mh[1:0] + modelSet[0].hScroll[1:0];
		expPix[0] = (ps == 2'd3);
		ps        = mh[1:0] + modelSet[1].hScroll[1:0];
		expPix[1] = (ps == 2'd3);
		// beam counters for the next cycle
		hf = !hSyncN && hLast;
		vf = !vSyncN && vLast;
		if (vf)
			mv = '0;
		else if (hf)
			mv = mv + 8'd1;
		mh    = hf ? 9'd0 : mh + 9'd1;
		hLast = hSyncN;
		vLast = vSyncN;
		slot  = slot + 2'd1;
	endtask

	always @(negedge CLK_6M) modelStep();

	////////////////////////////////////////////////////////////////////////////
	// bus tasks, entered and left 1 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic cpuWrite(input logic toReg, input logic [`CPU_ADDR_W-1:0] a,
			input logic [7:0] d);
		regCs     = toReg;
		ramCs     = !toReg;
		cpuWe     = 1'b1;
		cpuAddr   = a;
		cpuWrData = d;
		@(posedge CLK_6M);
		#1;
		regCs = 1'b0;
		ramCs = 1'b0;
		cpuWe = 1'b0;
	endtask

	task automatic ramRead(input logic [12:0] a, output logic [7:0] d);
		ramCs   = 1'b1;
		cpuWe   = 1'b0;
		cpuAddr = {1'b0, a};
		@(posedge CLK_6M);
		#1;
		ramCs = 1'b0;
		d     = cpuRdData;
	endtask

	// hlo, hhi, vsc for each layer
	task automatic writeScroll(input scrollSet s);
		logic lb;
		for (int l = 0; l < 2; l++) begin
			lb = l[0];
			cpuWrite(1'b1, {11'd0, lb, `REG_HLO}, s[lb].hScroll[7:0]);
			// priority in bits 3:1, hscroll msb in bit 0
			cpuWrite(1'b1, {11'd0, lb, `REG_HHI}, {4'b0000, s[lb].pri, s[lb].hScroll[8]});
			cpuWrite(1'b1, {11'd0, lb, `REG_VSC}, s[lb].vScroll);
		end
	endtask

	// frame start, then a few extra lines
	task automatic syncPulse(input int lines);
		vSyncN = 1'b0;
		hSyncN = 1'b0;
		@(posedge CLK_6M);
		#1;
		vSyncN = 1'b1;
		hSyncN = 1'b1;
		for (int k = 0; k < lines; k++) begin
			repeat (3) @(posedge CLK_6M);
			#1;
			hSyncN = 1'b0;
			@(posedge CLK_6M);
			#1;
			hSyncN = 1'b1;
		end
	endtask

	task automatic reportTest();
		testCount++;
		if (testErr == 0) begin
			$display("test %s ok", curName);
		end else begin
			$display("test %s: %0d errors", curName, testErr);
			failCount++;
			errTotal += testErr;
		end
	endtask

	task automatic runEntry(input int i);
		logic [2:0] e;
		e        = 3'(i);
		curName  = tblName[e];
		testErr  = 0;
		modelSet = tblSet[e];
		writeScroll(tblSet[e]);
		assert (pri === {tblSet[e][1].pri, tblSet[e][0].pri}) else begin
			$display("[ERROR] %s: pri expected %h, got %h",
				curName, {tblSet[e][1].pri, tblSet[e][0].pri}, pri);
			testErr++;
		end
		syncPulse(tblLines[e]);
		// let the pipe fill with the new scroll
		repeat (8) @(posedge CLK_6M);
		#1;
		fetchSeen = 0;
		haveLast  = 1'b0;
		checkOn   = 1'b1;
		for (int t = 0; t < tblFetches[e] * 4 + 64 && fetchSeen < tblFetches[e]; t++)
			@(posedge CLK_6M);
		#1;
		checkOn = 1'b0;
		if (fetchSeen < tblFetches[e]) begin
			$display("test %s timed out, fetchStrobe never arrived (%0d of %0d fetches)",
				curName, fetchSeen, tblFetches[e]);
			testErr++;
		end
		reportTest();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [12:0] a;
		logic [7:0]  d;
		logic [7:0]  rd;
		CLK_6M    = 1'b0;
		rst       = 1'b1;
		hSyncN    = 1'b1;
		vSyncN    = 1'b1;
		cpuAddr   = '0;
		cpuWrData = '0;
		cpuWe     = 1'b0;
		regCs     = 1'b0;
		ramCs     = 1'b0;
		checkOn   = 1'b0;
		haveLast  = 1'b0;
		lastLayer = 1'b0;
		fetchSeen = 0;
		testErr   = 0;
		testCount = 0;
		failCount = 0;
		errTotal  = 0;
		lcgState  = 32'ha7a9_0e3d;
		// name, layer 0 h/v/pri, layer 1 h/v/pri, extra lines, fetches
		setEntry(3'd0, "zeroScroll", 9'h000, 8'h00, 3'd0, 9'h000, 8'h00, 3'd0, 0, 48);
		setEntry(3'd1, "priHiBit", 9'h100, 8'h00, 3'd5, 9'h101, 8'h00, 3'd2, 1, 48);
		setEntry(3'd2, "colWrap", 9'h1c3, 8'h10, 3'd7, 9'h1f6, 8'h21, 3'd1, 3, 96);
		setEntry(3'd3, "rowWrap", 9'h02a, 8'hfe, 3'd4, 9'h155, 8'hff, 3'd6, 2, 64);
		setEntry(3'd4, "mixedScroll", 9'h0b7, 8'h9c, 3'd3, 9'h162, 8'h47, 3'd0, 5, 64);
		repeat (16) @(posedge CLK_6M);
		#1;
		rst = 1'b0;

		// outputs in the first cycle out of reset
		curName = "resetState";
		testErr = 0;
		@(negedge CLK_6M);
		assert (fetchStrobe === 1'b0 && pixLatch === 2'b00 && pri === '0) else begin
			$display("[ERROR] %s: outputs expected 0, got strobe %b latch %b pri %h",
				curName, fetchStrobe, pixLatch, pri);
			testErr++;
		end
		@(posedge CLK_6M);
		#1;
		reportTest();

		// both layers filled with random bytes
		for (int k = 0; k < 2**`RAM_ADDR_W; k++) begin
			a         = 13'(k);
			r         = nextRand();
			shadow[a] = r[23:16];
			cpuWrite(1'b0, {1'b0, a}, r[23:16]);
		end

		// write then read back at random spots
		curName = "ramReadback";
		testErr = 0;
		for (int k = 0; k < 16; k++) begin
			r = nextRand();
			a = r[28:16];
			r = nextRand();
			d = r[23:16];
			cpuWrite(1'b0, {1'b0, a}, d);
			shadow[a] = d;
			ramRead(a, rd);
			assert (rd === d) else begin
				$display("[ERROR] %s: cpuRdData at %h expected %h, got %h", curName, a, d, rd);
				testErr++;
			end
		end
		reportTest();

		for (int i = 0; i < N_TESTS; i++)
			runEntry(i);

		$display("tests %0d, failed %0d, errors %0d", testCount, failCount, errTotal);
		if (failCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/tilemapGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tilemap_defs.svh"

module tilemapGen (
	input  wire logic                    CLK_6M,
	input  wire logic                    rst,
	input  wire logic                    hSyncN,
	input  wire logic                    vSyncN,
	input  wire logic [`CPU_ADDR_W-1:0]  cpuAddr,
	input  wire logic [`DATA_W-1:0]      cpuWrData,
	input  wire logic                    cpuWe,
	input  wire logic                    regCs,
	input  wire logic                    ramCs,
	output logic [`DATA_W-1:0]           cpuRdData,
	output logic                         fetchStrobe,
	output videoAddrPkg::gfxFetch        gfxOut,
	output logic [1:0]                   pixLatch,
	output logic [1:0][2:0]              pri
);

	import cpuRegPkg::*;
	import videoAddrPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal wiring
	////////////////////////////////////////////////////////////////////////////

	regByte   regWrData;
	scrollSet regs;
	ramAddr   vidAddr;
	logic [`DATA_W-1:0] vidRdData;

	assign regWrData = cpuWrData;
	// priority goes out untouched, for the mixer
	assign pri[0] = regs[0].pri;
	assign pri[1] = regs[1].pri;

	scrollRegs i_scrollRegs (
		.CLK_6M    (CLK_6M),
		.rst       (rst),
		.regCs     (regCs),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr[2:0]),
		.cpuWrData (regWrData),
		.regs      (regs)
	);

	tileAddrGen i_tileAddrGen (
		.CLK_6M      (CLK_6M),
		.rst         (rst),
		.hSyncN      (hSyncN),
		.vSyncN      (vSyncN),
		.regs        (regs),
		.vidAddr     (vidAddr),
		.vidRdData   (vidRdData),
		.fetchStrobe (fetchStrobe),
		.gfxOut      (gfxOut),
		.pixLatch    (pixLatch)
	);

	// cpu sees the ram in the low 13 address bits
	tileRam i_tileRam (
		.CLK_6M    (CLK_6M),
		.ramCs     (ramCs),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr[`RAM_ADDR_W-1:0]),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.vidAddr   (vidAddr),
		.vidRdData (vidRdData)
	);

endmodule

`default_nettype wire

// ==== rtl/tileRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tilemap_defs.svh"

module tileRam (
	input  wire logic                    CLK_6M,
	input  wire logic                    ramCs,
	input  wire logic                    cpuWe,
	input  wire logic [`RAM_ADDR_W-1:0]  cpuAddr,
	input  wire logic [`DATA_W-1:0]      cpuWrData,
	output logic [`DATA_W-1:0]           cpuRdData,
	input  wire videoAddrPkg::ramAddr    vidAddr,
	output logic [`DATA_W-1:0]           vidRdData
);

	import videoAddrPkg::*;

	// two layers, two bytes per tile
	localparam int RAM_DEPTH = 2 * 2 * `TM_COLS * `TM_ROWS;

	////////////////////////////////////////////////////////////////////////////
	// single-port array
	////////////////////////////////////////////////////////////////////////////

	logic [`DATA_W-1:0]     mem [RAM_DEPTH];
	logic [`RAM_ADDR_W-1:0] accAddr;
	logic [`DATA_W-1:0]     rdQ;

	// cpu owns the port whenever selected
	assign accAddr = ramCs ? cpuAddr : vidAddr;

	always_ff @(posedge CLK_6M) begin
		if (ramCs && cpuWe)
			mem[accAddr] <= cpuWrData;
		// read-before-write, old byte on a write cycle
		rdQ <= mem[accAddr];
	end

	////////////////////////////////////////////////////////////////////////////
	// read data, one cycle after the access
	////////////////////////////////////////////////////////////////////////////

	// same byte to both sides
	// video result is only meaningful when ramCs was low
	assign cpuRdData = rdQ;
	assign vidRdData = rdQ;

endmodule

`default_nettype wire

// ==== rtl/tileAddrGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tilemap_defs.svh"

module tileAddrGen (
	input  wire logic                 CLK_6M,
	input  wire logic                 rst,
	input  wire logic                 hSyncN,
	input  wire logic                 vSyncN,
	input  wire cpuRegPkg::scrollSet  regs,
	output videoAddrPkg::ramAddr      vidAddr,
	input  wire logic [`DATA_W-1:0]   vidRdData,
	output logic                      fetchStrobe,
	output videoAddrPkg::gfxFetch     gfxOut,
	output logic [1:0]                pixLatch
);

	import cpuRegPkg::*;
	import videoAddrPkg::*;

	localparam int COL_W = $clog2(`TM_COLS);
	localparam int ROW_W = $clog2(`TM_ROWS);

	////////////////////////////////////////////////////////////////////////////
	// sync edges and beam counters
	////////////////////////////////////////////////////////////////////////////

	logic       hSyncLast;
	logic       vSyncLast;
	logic       hFall;
	logic       vFall;
	logic [8:0] hCount;
	logic [7:0] vCount;

	// falling edge: low now, high last sample
	assign hFall = ~hSyncN & hSyncLast;
	assign vFall = ~vSyncN & vSyncLast;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hSyncLast <= 1'b1;
			vSyncLast <= 1'b1;
			hCount    <= '0;
			vCount    <= '0;
		end else begin
			hSyncLast <= hSyncN;
			vSyncLast <= vSyncN;
			hCount    <= hFall ? 9'd0 : hCount + 9'd1;
			// vsync edge wins over the line increment
			if (vFall)
				vCount <= '0;
			else if (hFall)
				vCount <= vCount + 8'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// scrolled addressing, cycle n
	////////////////////////////////////////////////////////////////////////////

	logic             curLayer;
	logic             curByte;
	logic [8:0]       hPos;
	logic [7:0]       vPos;
	logic [COL_W-1:0] tileCol;
	logic [ROW_W-1:0] tileRow;

	// layers interleave every cycle, bytes every two
	assign curLayer = hCount[0];
	assign curByte  = hCount[1];
	// wraps at 512 and 256
	assign hPos     = hCount + regs[curLayer].hScroll;
	assign vPos     = vCount + regs[curLayer].vScroll;
	assign tileCol  = hPos[3 +: COL_W];
	assign tileRow  = vPos[3 +: ROW_W];

	// tag pipe, stage 1 with the address, stage 2 with the data
	fetchTag tag1;
	fetchTag tag2;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			vidAddr <= '0;
			tag1    <= '0;
			tag2    <= '0;
		end else begin
			vidAddr.layer         <= curLayer;
			vidAddr.tileIndex.row <= tileRow;
			vidAddr.tileIndex.col <= tileCol;
			vidAddr.byteSel       <= curByte;
			tag1.layer            <= curLayer;
			tag1.byteSel          <= curByte;
			tag1.row              <= vPos[2:0];
			tag1.nibble           <= hPos[2];
			// ram data comes back one cycle after the address
			tag2                  <= tag1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// byte capture and rom address
	////////////////////////////////////////////////////////////////////////////

	logic [7:0]             idxQ [2];
	logic [`GFX_ADDR_W-1:0] romWord;

	// byte 0 is the tile index for its layer
	always_ff @(posedge CLK_6M) begin
		if (!tag2.byteSel)
			idxQ[tag2.layer] <= vidRdData;
	end

	// attr from byte 1, stored index, row and nibble of the byte 1 request
	assign romWord = {vidRdData[1:0], idxQ[tag2.layer], tag2.row, tag2.nibble};

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			fetchStrobe <= 1'b0;
			gfxOut      <= '0;
			pixLatch    <= '0;
		end else begin
			// one pulse per returned byte 1, at n+3
			fetchStrobe <= tag2.byteSel;
			if (tag2.byteSel) begin
				gfxOut.layer <= tag2.layer;
				gfxOut.addr  <= romWord;
			end
			// per-layer pixel latch, modulo 4 of beam plus scroll
			for (int l = 0; l < 2; l++) begin
				pixLatch[l] <= 2'(hCount[1:0] + regs[l].hScroll[1:0]) == 2'd3;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/scrollRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tilemap_defs.svh"

module scrollRegs (
	input  wire logic                CLK_6M,
	input  wire logic                rst,
	input  wire logic                regCs,
	input  wire logic                cpuWe,
	input  wire logic [2:0]          cpuAddr,
	input  wire cpuRegPkg::regByte   cpuWrData,
	output cpuRegPkg::scrollSet      regs
);

	import cpuRegPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	regSel sel;
	logic  wrEn;

	// layer in bit 2, offset in bits 1:0
	assign sel  = cpuAddr;
	// write lands on the clock edge, visible next cycle
	assign wrEn = regCs & cpuWe;

	////////////////////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			// all scroll and priority values back to 0
			regs <= '0;
		end else if (wrEn) begin
			case (sel.offset)
				`REG_HLO: begin
					// low byte of hscroll, whole byte
					regs[sel.layer].hScroll[7:0] <= cpuWrData.raw;
				end
				`REG_HHI: begin
					// same byte split into priority and hscroll msb
					regs[sel.layer].hScroll[8] <= cpuWrData.f.hScrollHi;
					regs[sel.layer].pri        <= cpuWrData.f.pri;
				end
				`REG_VSC: begin
					// vscroll, whole byte
					regs[sel.layer].vScroll <= cpuWrData.raw;
				end
				default: begin
					// offset 3 is not mapped
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/videoAddrPkg.sv ====
`default_nettype none

package videoAddrPkg;

	// tile position in the 64x32 map
	typedef struct packed {
		logic [4:0] row;
		logic [5:0] col;
	} tileIdx;

	// tilemap ram byte address
	typedef struct packed {
		logic   layer;
		tileIdx tileIndex;
		logic   byteSel;
	} ramAddr;

	// graphics rom address
	typedef struct packed {
		logic [1:0] attr;
		logic [7:0] index;
		logic [2:0] row;
		logic       nibble;
	} gfxAddr;

	// fetch result, one per returned byte 1
	typedef struct packed {
		logic   layer;
		gfxAddr addr;
	} gfxFetch;

	// request info riding along with the ram address
	typedef struct packed {
		logic       layer;
		logic       byteSel;
		logic [2:0] row;
		logic       nibble;
	} fetchTag;

endpackage

`default_nettype wire

// ==== rtl/cpuRegPkg.sv ====
`default_nettype none

package cpuRegPkg;

	// register select, as seen in cpu address bits 2:0
	typedef struct packed {
		logic       layer;
		logic [1:0] offset;
	} regSel;

	// high-scroll register layout
	// bit 0 is hscroll bit 8, bits 3:1 priority
	typedef struct packed {
		logic [3:0] unused;
		logic [2:0] pri;
		logic       hScrollHi;
	} regFields;

	// one written byte, read either as a whole or as fields
	typedef union packed {
		logic [7:0] raw;
		regFields   f;
	} regByte;

	// scroll and priority of one layer
	typedef struct packed {
		logic [8:0] hScroll;
		logic [7:0] vScroll;
		logic [2:0] pri;
	} layerScroll;

	// both layers, indexed by layer bit
	typedef layerScroll [1:0] scrollSet;

endpackage

`default_nettype wire

// ==== rtl/tilemap_defs.svh ====
`ifndef TILEMAP_DEFS_SVH
`define TILEMAP_DEFS_SVH

// tilemap geometry, per layer
`define TM_COLS 64
`define TM_ROWS 32

// bus widths
`define DATA_W 8
// layer, 11-bit tile index, byte select
`define RAM_ADDR_W 13
`define CPU_ADDR_W 14
`define GFX_ADDR_W 14

// register offsets, cpu address bits 1:0
// bit 2 of the cpu address picks the layer
`define REG_HLO 2'd0
`define REG_HHI 2'd1
`define REG_VSC 2'd2

`endif
